/* all.f */
+incdir+.
sched_types_pkg.sv
sched_msg_pkg.sv
desc_slot_if.sv
slot_fifo.sv
ctrl_port.sv
rx_dispatcher.sv
sched_top.sv
sched_asserts.sv
tb_sched.sv

/* run.sh */
#!/bin/sh
# compile and run the scheduler testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert --top-module tb_sched -f all.f -o sim_sched \
  && ./obj_dir/sim_sched > sim.log 2>&1
grep -qx "Verification passed" sim.log && echo "run passed" \
  || { cat sim.log 2>/dev/null; echo "run failed"; exit 1; }

/* tb_sched.sv */
`timescale 1ns/1ps
`include "sched_settings.svh"

bind sched_top sched_asserts u_asserts (.*);

module tb_sched;

  localparam int DW = `SCHED_DATA_WIDTH;
  localparam int KW = `SCHED_DATA_WIDTH / 8;
  localparam int PKT_TARGET = 300;
  localparam int TIMEOUT_CYCLES = 20000;
  localparam int RX_START = 10;     // both registers loaded before traffic
  localparam int HOLD_START = 400;  // releases held so every slot gets taken
  localparam int HOLD_END = 700;

  logic                              clk;
  logic                              rst;
  logic [2*DW-1:0]                   rx_tdata;
  logic [2*KW-1:0]                   rx_tkeep;
  logic [1:0]                        rx_tvalid;
  logic [1:0]                        rx_tready;
  logic [1:0]                        rx_tlast;
  logic [2*DW-1:0]                   data_m_tdata;
  logic [2*KW-1:0]                   data_m_tkeep;
  sched_types_pkg::dest_t [1:0]      data_m_tdest;
  logic [1:0]                        data_m_tuser;
  logic [1:0]                        data_m_tvalid;
  logic [1:0]                        data_m_tready;
  logic [1:0]                        data_m_tlast;
  logic [DW-1:0]                     ctrl_s_tdata;
  logic                              ctrl_s_tvalid;
  logic                              ctrl_s_tready;
  logic                              ctrl_s_tlast;
  sched_types_pkg::core_id_t         ctrl_s_tuser;
  logic [DW-1:0]                     ctrl_m_tdata;
  logic                              ctrl_m_tvalid;
  logic                              ctrl_m_tready;
  logic                              ctrl_m_tlast;
  sched_types_pkg::core_id_t         ctrl_m_tdest;

  int                      cycle;
  int                      pkt_done;
  int                      beats_left [2];
  int                      rel_due [$];
  sched_types_pkg::dest_t  rel_tag [$];

  sched_top u_sched_top (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    void'($urandom(32'hcbd3_6049));
    rst           = 1'b1;
    rx_tdata      = '0;
    rx_tkeep      = '0;
    rx_tvalid     = '0;
    rx_tlast      = '0;
    data_m_tready = '0;
    ctrl_s_tdata  = '0;
    ctrl_s_tvalid = 1'b0;
    ctrl_s_tlast  = 1'b0;
    ctrl_s_tuser  = '0;
    ctrl_m_tready = 1'b0;
    cycle         = 0;
    pkt_done      = 0;
    beats_left    = '{0, 0};
    repeat (5) @(posedge clk);
    rst <= 1'b0;
  end

  task automatic send_beat(input int p);
    beats_left[p] = beats_left[p] - 1;
    rx_tdata[p*DW +: DW] <= {$urandom, $urandom};
    rx_tvalid[p]         <= 1'b1;
    rx_tlast[p]          <= (beats_left[p] == 0);
    if (beats_left[p] == 0) begin
      rx_tkeep[p*KW +: KW] <= KW'($urandom_range(1, (1 << KW) - 1)); // partial last word
    end else begin
      rx_tkeep[p*KW +: KW] <= '1;
    end
  endtask

  // rx packets and sink back-pressure
  always @(posedge clk) begin
    if (!rst) begin
      data_m_tready <= 2'($urandom);
      ctrl_m_tready <= (cycle < 30) ? 1'($urandom) : 1'b1;
      for (int p = 0; p < 2; p++) begin
        if (rx_tvalid[p] && rx_tready[p]) begin
          if (rx_tlast[p]) begin
            rx_tvalid[p] <= 1'b0;
          end else begin
            send_beat(p);
          end
        end else if (!rx_tvalid[p] && cycle >= RX_START && $urandom_range(0, 2) == 0) begin
          beats_left[p] = $urandom_range(1, 6);
          send_beat(p);
        end
      end
    end
  end

  // hand slots back once packets are done
  always @(posedge clk) begin
    logic [DW-1:0] word;
    int            fin;
    fin = 0;
    if (!rst) begin
      if (ctrl_s_tvalid && ctrl_s_tready) begin
        ctrl_s_tvalid <= 1'b0;
      end else if (!ctrl_s_tvalid && rel_due.size() > 0 && rel_due[0] <= cycle &&
                   !(cycle >= HOLD_START && cycle < HOLD_END)) begin
        word = {$urandom, $urandom};
        word[sched_msg_pkg::RELEASE_ADDR_LSB +: `SCHED_SLOT_ADDR_W] = rel_tag[0].slot;
        ctrl_s_tdata  <= word;
        ctrl_s_tuser  <= rel_tag[0].core;
        ctrl_s_tlast  <= 1'b1;
        ctrl_s_tvalid <= 1'b1;
        void'(rel_due.pop_front());
        void'(rel_tag.pop_front());
      end
      for (int p = 0; p < 2; p++) begin
        if (data_m_tvalid[p] && data_m_tready[p] && data_m_tlast[p]) begin
          rel_tag.push_back(data_m_tdest[p]);
          rel_due.push_back(cycle + $urandom_range(1, 25));
          fin = fin + 1;
        end
      end
      pkt_done <= pkt_done + fin;
    end
  end

  // end of run
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (u_sched_top.u_asserts.fail_cnt != 0) begin
      $display("Verification failed");
      $fatal(1, "assertion failure reported above");
    end else if (pkt_done >= PKT_TARGET) begin
      $display("Verification passed");
      $finish;
    end else if (cycle >= TIMEOUT_CYCLES) begin
      $display("TIMEOUT after %0d cycles with %0d packets done", cycle, pkt_done);
      $display("Verification failed");
      $fatal(1, "run stopped by timeout");
    end
  end

endmodule

/* sched_asserts.sv */
`timescale 1ns/1ps
`include "sched_settings.svh"

module sched_asserts (
  input logic                              clk,
  input logic                              rst,
  input logic [2*`SCHED_DATA_WIDTH-1:0]    rx_tdata,
  input logic [2*`SCHED_DATA_WIDTH/8-1:0]  rx_tkeep,
  input logic [1:0]                        rx_tvalid,
  input logic [1:0]                        rx_tready,
  input logic [1:0]                        rx_tlast,
  input logic [2*`SCHED_DATA_WIDTH-1:0]    data_m_tdata,
  input logic [2*`SCHED_DATA_WIDTH/8-1:0]  data_m_tkeep,
  input sched_types_pkg::dest_t [1:0]      data_m_tdest,
  input logic [1:0]                        data_m_tuser,
  input logic [1:0]                        data_m_tvalid,
  input logic [1:0]                        data_m_tready,
  input logic [1:0]                        data_m_tlast,
  input logic [`SCHED_DATA_WIDTH-1:0]      ctrl_s_tdata,
  input logic                              ctrl_s_tvalid,
  input logic                              ctrl_s_tready,
  input logic                              ctrl_s_tlast,
  input sched_types_pkg::core_id_t         ctrl_s_tuser,
  input logic [`SCHED_DATA_WIDTH-1:0]      ctrl_m_tdata,
  input logic                              ctrl_m_tvalid,
  input logic                              ctrl_m_tready,
  input logic                              ctrl_m_tlast,
  input sched_types_pkg::core_id_t         ctrl_m_tdest
);

  localparam int DW = `SCHED_DATA_WIDTH;
  localparam int KW = `SCHED_DATA_WIDTH / 8;
  localparam int NPAIR = `SCHED_CORE_COUNT * `SCHED_SLOT_COUNT;
  localparam logic [DW-1:0] RST_CMD = {{(DW-1){1'b1}}, 1'b0};

  int                      fail_cnt = 0; // read by the testbench
  int                      cmd_seen;
  logic [1:0]              in_pkt;
  logic [1:0]              started_once;
  sched_types_pkg::dest_t  first_tag [2];
  logic [NPAIR-1:0]        taken;      // (core, slot) pairs owned by a packet
  logic [1:0]              rx_xfer;
  logic [1:0]              m_xfer;
  logic [1:0]              pkt_start;
  int                      tag_idx [2];
  sched_types_pkg::dest_t  rel_tag;

  // -1 for an address that is no slot of any core
  function automatic int pair_index(input sched_types_pkg::dest_t t);
    int off;
    off = int'(t.slot) - int'(`SCHED_SLOT_START);
    if (off < 0 || off % int'(`SCHED_SLOT_STEP) != 0) begin
      return -1;
    end
    if (off / int'(`SCHED_SLOT_STEP) >= `SCHED_SLOT_COUNT) begin
      return -1;
    end
    return int'(t.core) * `SCHED_SLOT_COUNT + off / int'(`SCHED_SLOT_STEP);
  endfunction

  assign rx_xfer   = rx_tvalid & rx_tready;
  assign m_xfer    = data_m_tvalid & data_m_tready;
  assign pkt_start = rx_xfer & ~in_pkt;
  assign tag_idx[0] = pair_index(data_m_tdest[0]);
  assign tag_idx[1] = pair_index(data_m_tdest[1]);
  assign rel_tag   = '{core: ctrl_s_tuser, slot: ctrl_s_tdata[16 +: `SCHED_SLOT_ADDR_W]};

  always_ff @(posedge clk) begin
    int idx;
    if (rst) begin
      cmd_seen     <= 0;
      in_pkt       <= '0;
      started_once <= '0;
      taken        <= '0;
    end else begin
      if (ctrl_m_tvalid && ctrl_m_tready) begin
        cmd_seen <= cmd_seen + 1;
      end
      idx = pair_index(rel_tag);
      if (ctrl_s_tvalid && ctrl_s_tready && ctrl_s_tlast && idx >= 0) begin
        taken[idx] <= 1'b0; // slot back with its core
      end
      for (int p = 0; p < 2; p++) begin
        if (pkt_start[p]) begin
          first_tag[p]    <= data_m_tdest[p];
          started_once[p] <= 1'b1;
          if (tag_idx[p] >= 0) begin
            taken[tag_idx[p]] <= 1'b1;
          end
        end
        if (rx_xfer[p]) begin
          in_pkt[p] <= ~rx_tlast[p];
        end
      end
    end
  end

  // reset commands
  a_cmd_dest: assert property (@(posedge clk) disable iff (rst)
    ctrl_m_tvalid |-> ctrl_m_tdest == sched_types_pkg::core_id_t'(cmd_seen))
    else begin
      fail_cnt++;
      $error("MISMATCH t=%0t ctrl_m_tdest exp %0d act %0d", $time,
             $sampled(cmd_seen), $sampled(ctrl_m_tdest));
    end
  a_cmd_word: assert property (@(posedge clk) disable iff (rst)
    ctrl_m_tvalid |-> ctrl_m_tdata == RST_CMD)
    else begin
      fail_cnt++;
      $error("MISMATCH t=%0t ctrl_m_tdata exp %h act %h", $time,
             RST_CMD, $sampled(ctrl_m_tdata));
    end
  a_cmd_last: assert property (@(posedge clk) disable iff (rst)
    ctrl_m_tvalid |-> ctrl_m_tlast)
    else begin
      fail_cnt++;
      $error("MISMATCH t=%0t ctrl_m_tlast exp 1 act %0d", $time,
             $sampled(ctrl_m_tlast));
    end
  a_cmd_hold: assert property (@(posedge clk) disable iff (rst)
    ctrl_m_tvalid && !ctrl_m_tready |=> ctrl_m_tvalid && $stable(ctrl_m_tdest))
    else begin
      fail_cnt++;
      $error("command changed or dropped under back-pressure at t=%0t", $time);
    end
  a_cmd_count: assert property (@(posedge clk) disable iff (rst)
    ctrl_m_tvalid == (cmd_seen < `SCHED_CORE_COUNT))
    else begin
      fail_cnt++;
      $error("MISMATCH t=%0t ctrl_m_tvalid exp %0d act %0d", $time,
             $sampled(cmd_seen) < `SCHED_CORE_COUNT, $sampled(ctrl_m_tvalid));
    end

  // a core only hands back a slot it holds, so its fifo has room
  a_rel_ready: assert property (@(posedge clk) disable iff (rst)
    ctrl_s_tvalid |-> ctrl_s_tready)
    else begin
      fail_cnt++;
      $error("MISMATCH t=%0t ctrl_s_tready exp 1 act %0d", $time,
             $sampled(ctrl_s_tready));
    end

  for (genvar p = 0; p < 2; p++) begin : g_port
    localparam sched_types_pkg::dest_t FIRST = '{
      core: sched_types_pkg::core_id_t'(p),
      slot: sched_types_pkg::slot_addr_t'(`SCHED_SLOT_START)};

    a_data: assert property (@(posedge clk) disable iff (rst)
      data_m_tdata[p*DW +: DW] == rx_tdata[p*DW +: DW])
      else begin
        fail_cnt++;
        $error("MISMATCH t=%0t data_m_tdata[%0d] exp %h act %h", $time, p,
               $sampled(rx_tdata[p*DW +: DW]), $sampled(data_m_tdata[p*DW +: DW]));
      end
    a_keep: assert property (@(posedge clk) disable iff (rst)
      data_m_tkeep[p*KW +: KW] == rx_tkeep[p*KW +: KW])
      else begin
        fail_cnt++;
        $error("MISMATCH t=%0t data_m_tkeep[%0d] exp %h act %h", $time, p,
               $sampled(rx_tkeep[p*KW +: KW]), $sampled(data_m_tkeep[p*KW +: KW]));
      end
    a_last: assert property (@(posedge clk) disable iff (rst)
      data_m_tlast[p] == rx_tlast[p])
      else begin
        fail_cnt++;
        $error("MISMATCH t=%0t data_m_tlast[%0d] exp %0d act %0d", $time, p,
               $sampled(rx_tlast[p]), $sampled(data_m_tlast[p]));
      end
    a_user: assert property (@(posedge clk) disable iff (rst)
      data_m_tuser[p] == 1'(p))
      else begin
        fail_cnt++;
        $error("MISMATCH t=%0t data_m_tuser[%0d] exp %0d act %0d", $time, p,
               p, $sampled(data_m_tuser[p]));
      end
    a_xfer: assert property (@(posedge clk) disable iff (rst)
      m_xfer[p] == rx_xfer[p])
      else begin
        fail_cnt++;
        $error("MISMATCH t=%0t data_m transfer[%0d] exp %0d act %0d", $time, p,
               $sampled(rx_xfer[p]), $sampled(m_xfer[p]));
      end
    a_tag_stable: assert property (@(posedge clk) disable iff (rst)
      m_xfer[p] && in_pkt[p] |-> data_m_tdest[p] == first_tag[p])
      else begin
        fail_cnt++;
        $error("MISMATCH t=%0t data_m_tdest[%0d] exp %h act %h", $time, p,
               $sampled(first_tag[p]), $sampled(data_m_tdest[p]));
      end
    a_slot_legal: assert property (@(posedge clk) disable iff (rst)
      pkt_start[p] |-> tag_idx[p] >= 0)
      else begin
        fail_cnt++;
        $error("illegal slot address %h on port %0d at t=%0t",
               $sampled(data_m_tdest[p].slot), p, $time);
      end
    a_slot_free: assert property (@(posedge clk) disable iff (rst)
      pkt_start[p] && tag_idx[p] >= 0 |-> !taken[tag_idx[p]])
      else begin
        fail_cnt++;
        $error("slot %h of core %0d handed out twice at t=%0t",
               $sampled(data_m_tdest[p].slot), $sampled(data_m_tdest[p].core), $time);
      end
    a_first: assert property (@(posedge clk) disable iff (rst)
      pkt_start[p] && !started_once[p] |-> data_m_tdest[p] == FIRST)
      else begin
        fail_cnt++;
        $error("MISMATCH t=%0t data_m_tdest[%0d] exp %h act %h", $time, p,
               FIRST, $sampled(data_m_tdest[p]));
      end
    a_exhaust: assert property (@(posedge clk) disable iff (rst)
      (&taken) && !in_pkt[p] |-> !rx_xfer[p])
      else begin
        fail_cnt++;
        $error("packet accepted on port %0d with no free slot at t=%0t", p, $time);
      end
  end

endmodule

/* sched_top.sv */
`timescale 1ns/1ps
`include "sched_settings.svh"

module sched_top (
  input  logic                              clk,
  input  logic                              rst,

  // ethernet receive ports
  input  logic [2*`SCHED_DATA_WIDTH-1:0]    rx_tdata,
  input  logic [2*`SCHED_DATA_WIDTH/8-1:0]  rx_tkeep,
  input  logic [1:0]                        rx_tvalid,
  output logic [1:0]                        rx_tready,
  input  logic [1:0]                        rx_tlast,

  // packets to the cores
  output logic [2*`SCHED_DATA_WIDTH-1:0]    data_m_tdata,
  output logic [2*`SCHED_DATA_WIDTH/8-1:0]  data_m_tkeep,
  output sched_types_pkg::dest_t [1:0]      data_m_tdest,
  output logic [1:0]                        data_m_tuser,
  output logic [1:0]                        data_m_tvalid,
  input  logic [1:0]                        data_m_tready,
  output logic [1:0]                        data_m_tlast,

  // control messages from the cores
  input  logic [`SCHED_DATA_WIDTH-1:0]      ctrl_s_tdata,
  input  logic                              ctrl_s_tvalid,
  output logic                              ctrl_s_tready,
  input  logic                              ctrl_s_tlast,
  input  sched_types_pkg::core_id_t         ctrl_s_tuser,

  // control messages to the cores
  output logic [`SCHED_DATA_WIDTH-1:0]      ctrl_m_tdata,
  output logic                              ctrl_m_tvalid,
  input  logic                              ctrl_m_tready,
  output logic                              ctrl_m_tlast,
  output sched_types_pkg::core_id_t         ctrl_m_tdest
);

  logic [`SCHED_CORE_COUNT-1:0] push_valid;
  logic [`SCHED_CORE_COUNT-1:0] push_ready;
  sched_types_pkg::slot_addr_t  push_slot; // shared, push_valid picks the core

  desc_slot_if slots [`SCHED_CORE_COUNT] ();

  ctrl_port u_ctrl_port (
    .clk           (clk),
    .rst           (rst),
    .ctrl_s_tdata  (ctrl_s_tdata),
    .ctrl_s_tvalid (ctrl_s_tvalid),
    .ctrl_s_tready (ctrl_s_tready),
    .ctrl_s_tlast  (ctrl_s_tlast),
    .ctrl_s_tuser  (ctrl_s_tuser),
    .ctrl_m_tdata  (ctrl_m_tdata),
    .ctrl_m_tvalid (ctrl_m_tvalid),
    .ctrl_m_tready (ctrl_m_tready),
    .ctrl_m_tlast  (ctrl_m_tlast),
    .ctrl_m_tdest  (ctrl_m_tdest),
    .push_valid    (push_valid),
    .push_slot     (push_slot),
    .push_ready    (push_ready)
  );

  // one free-slot fifo per core
  for (genvar i = 0; i < `SCHED_CORE_COUNT; i++) begin : g_fifo
    slot_fifo u_slot_fifo (
      .clk        (clk),
      .rst        (rst),
      .push_valid (push_valid[i]),
      .push_slot  (push_slot),
      .push_ready (push_ready[i]),
      .drain      (slots[i])
    );
  end

  rx_dispatcher u_rx_dispatcher (
    .clk           (clk),
    .rst           (rst),
    .rx_tdata      (rx_tdata),
    .rx_tkeep      (rx_tkeep),
    .rx_tvalid     (rx_tvalid),
    .rx_tready     (rx_tready),
    .rx_tlast      (rx_tlast),
    .data_m_tdata  (data_m_tdata),
    .data_m_tkeep  (data_m_tkeep),
    .data_m_tdest  (data_m_tdest),
    .data_m_tuser  (data_m_tuser),
    .data_m_tvalid (data_m_tvalid),
    .data_m_tready (data_m_tready),
    .data_m_tlast  (data_m_tlast),
    .slots         (slots)
  );

endmodule

/* rx_dispatcher.sv */
`timescale 1ns/1ps
`include "sched_settings.svh"

module rx_dispatcher (
  input  logic                              clk,
  input  logic                              rst,

  // two ethernet receive ports, packed side by side
  input  logic [2*`SCHED_DATA_WIDTH-1:0]    rx_tdata,
  input  logic [2*`SCHED_DATA_WIDTH/8-1:0]  rx_tkeep,
  input  logic [1:0]                        rx_tvalid,
  output logic [1:0]                        rx_tready,
  input  logic [1:0]                        rx_tlast,

  // tagged streams towards the cores
  output logic [2*`SCHED_DATA_WIDTH-1:0]    data_m_tdata,
  output logic [2*`SCHED_DATA_WIDTH/8-1:0]  data_m_tkeep,
  output sched_types_pkg::dest_t [1:0]      data_m_tdest,
  output logic [1:0]                        data_m_tuser,
  output logic [1:0]                        data_m_tvalid,
  input  logic [1:0]                        data_m_tready,
  output logic [1:0]                        data_m_tlast,

  desc_slot_if.sel                          slots [`SCHED_CORE_COUNT]
);

  sched_types_pkg::slot_cnt_t   cnt [`SCHED_CORE_COUNT];
  sched_types_pkg::slot_addr_t  head_slot [`SCHED_CORE_COUNT];
  logic [`SCHED_CORE_COUNT-1:0] head_valid;

  sched_types_pkg::core_id_t    sel_core;
  sched_types_pkg::slot_cnt_t   best_cnt;
  logic                         sel_valid;
  logic                         pop_any;

  sched_types_pkg::dest_t [1:0] dest_r;
  logic [1:0]                   dest_v;
  logic [1:0]                   last_xfer;
  logic [1:0]                   free;
  logic [1:0]                   load;

  for (genvar i = 0; i < `SCHED_CORE_COUNT; i++) begin : g_core
    assign cnt[i]        = slots[i].count;
    assign head_slot[i]  = slots[i].slot;
    assign head_valid[i] = slots[i].valid;
    assign slots[i].pop  = pop_any & (sel_core == sched_types_pkg::core_id_t'(i));
  end

  // most free slots wins, strict compare keeps the lowest index on a tie
  always_comb begin
    sel_core = '0;
    best_cnt = cnt[0];
    for (int i = 1; i < `SCHED_CORE_COUNT; i++) begin
      if (cnt[i] > best_cnt) begin
        sel_core = sched_types_pkg::core_id_t'(i);
        best_cnt = cnt[i];
      end
    end
  end

  assign sel_valid = head_valid[sel_core]; // low only when all cores are empty

  assign last_xfer = rx_tvalid & rx_tready & rx_tlast;
  assign free      = ~dest_v | last_xfer;

  // port 0 first, one refill per cycle
  assign load[0] = free[0] & sel_valid;
  assign load[1] = free[1] & ~free[0] & sel_valid;
  assign pop_any = |load;

  always_ff @(posedge clk) begin
    if (rst) begin
      dest_v <= '0;
    end else begin
      for (int p = 0; p < 2; p++) begin
        if (load[p]) begin
          dest_v[p] <= 1'b1;
        end else if (last_xfer[p]) begin
          dest_v[p] <= 1'b0; // waits for a slot next cycle
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < 2; p++) begin
      if (load[p]) begin
        dest_r[p] <= '{core: sel_core, slot: head_slot[sel_core]};
      end
    end
  end

  assign data_m_tdata  = rx_tdata;
  assign data_m_tkeep  = rx_tkeep;
  assign data_m_tlast  = rx_tlast;
  assign data_m_tdest  = dest_r;
  assign data_m_tuser  = 2'b10; // receive port index per lane
  assign data_m_tvalid = rx_tvalid & dest_v;
  assign rx_tready     = data_m_tready & dest_v; // no slot, no accept

endmodule

/* ctrl_port.sv */
`timescale 1ns/1ps
`include "sched_settings.svh"

module ctrl_port (
  input  logic                          clk,
  input  logic                          rst,

  // releases coming back from the cores
  input  logic [`SCHED_DATA_WIDTH-1:0]  ctrl_s_tdata,
  input  logic                          ctrl_s_tvalid,
  output logic                          ctrl_s_tready,
  input  logic                          ctrl_s_tlast,
  input  sched_types_pkg::core_id_t     ctrl_s_tuser,

  // reset commands out to the cores
  output logic [`SCHED_DATA_WIDTH-1:0]  ctrl_m_tdata,
  output logic                          ctrl_m_tvalid,
  input  logic                          ctrl_m_tready,
  output logic                          ctrl_m_tlast,
  output sched_types_pkg::core_id_t     ctrl_m_tdest,

  // towards the slot fifos
  output logic [`SCHED_CORE_COUNT-1:0]  push_valid,
  output sched_types_pkg::slot_addr_t   push_slot,
  input  logic [`SCHED_CORE_COUNT-1:0]  push_ready
);

  localparam int CNT_W = sched_types_pkg::CORE_ID_W + 1;
  localparam logic [CNT_W-1:0] CMD_TOTAL = CNT_W'(`SCHED_CORE_COUNT);

  logic [CNT_W-1:0] cmd_cnt;

  // release word, slot address taken from its field
  assign push_slot =
    ctrl_s_tdata[sched_msg_pkg::RELEASE_ADDR_MSB:sched_msg_pkg::RELEASE_ADDR_LSB];

  // only the last beat of a message carries the slot, earlier beats are dropped
  always_comb begin
    for (int i = 0; i < `SCHED_CORE_COUNT; i++) begin
      push_valid[i] = ctrl_s_tvalid & ctrl_s_tlast &
                      (ctrl_s_tuser == sched_types_pkg::core_id_t'(i));
    end
  end

  assign ctrl_s_tready = push_ready[ctrl_s_tuser] | ~ctrl_s_tlast;

  // one reset command per core, then silent
  always_ff @(posedge clk) begin
    if (rst) begin
      cmd_cnt <= '0;
    end else if (ctrl_m_tvalid && ctrl_m_tready) begin
      cmd_cnt <= cmd_cnt + 1'b1;
    end
  end

  assign ctrl_m_tvalid = (cmd_cnt < CMD_TOTAL);
  assign ctrl_m_tdata  = sched_msg_pkg::CORE_RST_CMD;
  assign ctrl_m_tlast  = 1'b1; // single beat command
  assign ctrl_m_tdest  = cmd_cnt[CNT_W-2:0];

endmodule

/* slot_fifo.sv */
`timescale 1ns/1ps
`include "sched_settings.svh"

module slot_fifo (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        push_valid,
  input  sched_types_pkg::slot_addr_t push_slot,
  output logic                        push_ready,
  desc_slot_if.fifo                   drain
);

  localparam int PTR_W = (`SCHED_SLOT_COUNT > 1) ? $clog2(`SCHED_SLOT_COUNT) : 1;
  localparam sched_types_pkg::slot_cnt_t FULL =
    sched_types_pkg::slot_cnt_t'(`SCHED_SLOT_COUNT);

  sched_types_pkg::slot_addr_t mem [`SCHED_SLOT_COUNT];
  logic [PTR_W-1:0]            rd_ptr;
  logic [PTR_W-1:0]            wr_ptr;
  sched_types_pkg::slot_cnt_t  cnt;
  logic                        do_push;
  logic                        do_pop;

  // wraps at the slot count, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    if (p == PTR_W'(`SCHED_SLOT_COUNT - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  assign push_ready = (cnt != FULL);
  assign do_push    = push_valid & push_ready;
  assign do_pop     = drain.pop & drain.valid;

  assign drain.valid = (cnt != '0);
  assign drain.slot  = mem[rd_ptr]; // head shows without a register stage
  assign drain.count = cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      // every slot of this core starts out free
      for (int k = 0; k < `SCHED_SLOT_COUNT; k++) begin
        mem[k] <= sched_types_pkg::slot_addr_t'(`SCHED_SLOT_START + k * `SCHED_SLOT_STEP);
      end
      rd_ptr <= '0;
      wr_ptr <= '0; // full, so write side wrapped onto read side
      cnt    <= FULL;
    end else begin
      if (do_push) begin
        mem[wr_ptr] <= push_slot;
        wr_ptr      <= ptr_inc(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      unique case ({do_push, do_pop})
        2'b10:   cnt <= cnt + 1'b1;
        2'b01:   cnt <= cnt - 1'b1;
        default: cnt <= cnt; // both or neither
      endcase
    end
  end

endmodule

/* desc_slot_if.sv */
`timescale 1ns/1ps

interface desc_slot_if;

  logic                        valid; // head slot present
  sched_types_pkg::slot_addr_t slot;  // head slot address
  sched_types_pkg::slot_cnt_t  count; // free slots held
  logic                        pop;   // ignored while valid is low

  modport fifo (
    output valid,
    output slot,
    output count,
    input  pop
  );

  modport sel (
    input  valid,
    input  slot,
    input  count,
    output pop
  );

endinterface

/* sched_msg_pkg.sv */
`include "sched_settings.svh"

package sched_msg_pkg;

  // release message from a core
  // slot being handed back sits in a field starting at bit 16,
  // the sending core comes in on tuser
  localparam int RELEASE_ADDR_LSB = 16;
  localparam int RELEASE_ADDR_MSB = RELEASE_ADDR_LSB + `SCHED_SLOT_ADDR_W - 1;

  // reset command sent once to every core after reset
  localparam logic [`SCHED_DATA_WIDTH-1:0] CORE_RST_CMD =
    {{(`SCHED_DATA_WIDTH-1){1'b1}}, 1'b0};

endpackage

/* sched_types_pkg.sv */
`include "sched_settings.svh"

package sched_types_pkg;

  // a single core still needs one id bit
  localparam int CORE_ID_W = (`SCHED_CORE_COUNT > 1) ? $clog2(`SCHED_CORE_COUNT) : 1;

  // one extra bit so a full fifo fits
  localparam int SLOT_CNT_W = $clog2(`SCHED_SLOT_COUNT) + 1;

  typedef logic [CORE_ID_W-1:0] core_id_t;

  typedef logic [`SCHED_SLOT_ADDR_W-1:0] slot_addr_t;

  typedef logic [SLOT_CNT_W-1:0] slot_cnt_t;

  // routing tag stamped on each packet, core in the upper bits
  typedef struct packed {
    core_id_t   core;
    slot_addr_t slot;
  } dest_t;

endpackage

/* sched_settings.svh */
`ifndef SCHED_SETTINGS_SVH
`define SCHED_SETTINGS_SVH

// processing cores fed by the scheduler
`define SCHED_CORE_COUNT 4

// packet buffer slots owned by each core
`define SCHED_SLOT_COUNT 4

// data and control stream word width
`define SCHED_DATA_WIDTH 64

// slot address inside a core's packet memory
`define SCHED_SLOT_ADDR_W 8
`define SCHED_SLOT_START  8'h20
`define SCHED_SLOT_STEP   8'h08

`endif
